// File: logic/array_multiplier.sv
`timescale 1ns/1ns

module array_multiplier (
    input  logic [mul_pkg::OPERAND_W-1:0] a,
    input  logic [mul_pkg::OPERAND_W-1:0] b,
    output logic [mul_pkg::PRODUCT_W-1:0] product
);

    logic [mul_pkg::OPERAND_W-1:0] pp [mul_pkg::OPERAND_W];

    logic [3:0]  s1, s2, s3, s4, s5, s6, s7, s9, s10, s11;
    logic [1:0]  s8;
    logic        c1, c2, c3, c4, c5, c6, c7, c8, c9, c10, c11;
    logic [13:0] fin_x, fin_y, fin_sum;
    logic        fin_cout;

    // row i is b gated by a[i], weight of pp[i][j] is i+j.
    for (genvar i = 0; i < mul_pkg::OPERAND_W; i++) begin : g_pp
        assign pp[i] = b & {mul_pkg::OPERAND_W{a[i]}};
    end

    // stage 1, middle columns 5 to 10.
    cla_block #(.WIDTH(4)) cla_1_i (
        .x({pp[1][7], pp[0][7], pp[0][6], pp[0][5]}),
        .y({pp[2][6], pp[1][6], pp[1][5], pp[1][4]}),
        .cin(1'b0), .sum(s1), .cout(c1));
    cla_block #(.WIDTH(4)) cla_2_i (
        .x({pp[2][7], pp[3][5], pp[2][5], pp[2][4]}),
        .y({pp[3][6], pp[4][4], pp[3][4], pp[3][3]}),
        .cin(1'b0), .sum(s2), .cout(c2));
    cla_block #(.WIDTH(4)) cla_3_i (
        .x({pp[3][7], pp[4][5], pp[5][3], pp[4][3]}),
        .y({pp[4][6], pp[5][4], pp[6][2], pp[5][2]}),
        .cin(1'b0), .sum(s3), .cout(c3));

    // stage 2.
    cla_block #(.WIDTH(4)) cla_4_i (
        .x({pp[4][2], pp[2][3], pp[0][4], pp[0][3]}),
        .y({pp[5][1], pp[3][2], pp[1][3], pp[1][2]}),
        .cin(1'b0), .sum(s4), .cout(c4));
    cla_block #(.WIDTH(4)) cla_5_i (
        .x({pp[6][1], pp[6][0], pp[4][1], pp[2][2]}),
        .y({pp[7][0], s1[1], pp[5][0], pp[3][1]}),
        .cin(1'b0), .sum(s5), .cout(c5));
    cla_block #(.WIDTH(4)) cla_6_i (
        .x({pp[5][5], pp[6][3], pp[7][1], s2[1]}),
        .y({pp[6][4], pp[7][2], 1'b0, s3[0]}),
        .cin(s1[2]), .sum(s6), .cout(c6));
    cla_block #(.WIDTH(4)) cla_7_i (
        .x({pp[4][7], pp[7][3], c1, s2[2]}),
        .y({pp[5][6], c2, s2[3], s3[1]}),
        .cin(s1[3]), .sum(s7), .cout(c7));
    cla_block #(.WIDTH(2)) cla_8_i (
        .x({pp[5][7], pp[7][4]}),
        .y({pp[6][6], c3}),
        .cin(pp[6][5]), .sum(s8), .cout(c8));

    // stage 3.
    cla_block #(.WIDTH(4)) cla_9_i (
        .x({s1[0], pp[4][0], pp[2][1], pp[0][2]}),
        .y({s4[2], s4[1], pp[3][0], pp[1][1]}),
        .cin(1'b0), .sum(s9), .cout(c9));
    cla_block #(.WIDTH(4)) cla_10_i (
        .x({s3[2], c5, c4, s4[3]}),
        .y({s6[2], s6[1], s5[3], s5[2]}),
        .cin(s2[0]), .sum(s10), .cout(c10));
    cla_block #(.WIDTH(4)) cla_11_i (
        .x({pp[6][7], pp[7][5], c6, s6[3]}),
        .y({pp[7][6], c7, s7[3], s7[2]}),
        .cin(s3[3]), .sum(s11), .cout(c11));

    // final two rows, weights 1 to 14.
    assign fin_x = {pp[7][7], c8, s8[1], s8[0], c10, s7[1], s7[0],
                    s6[0], c9, s5[1], s5[0], s4[0], pp[2][0], pp[0][1]};
    assign fin_y = {c11, s11[3], s11[2], s11[1], s11[0], s10[3], s10[2],
                    s10[1], s10[0], s9[3], s9[2], s9[1], s9[0], pp[1][0]};

    kogge_stone_adder #(.WIDTH(14)) final_add_i (
        .x(fin_x),
        .y(fin_y),
        .sum(fin_sum),
        .cout(fin_cout)
    );

    assign product = {fin_cout, fin_sum, pp[0][0]};

endmodule

// File: logic/cla_block.sv
`timescale 1ns/1ns

module cla_block #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH-1:0] gen;
    logic [WIDTH-1:0] prop;
    logic             carry;

    assign gen  = x & y;
    assign prop = x ^ y;

    // carry ripples from bit 0 upward.
    always_comb begin
        carry = cin;
        for (int i = 0; i < WIDTH; i++) begin
            sum[i] = prop[i] ^ carry;
            carry  = gen[i] | (prop[i] & carry);
        end
        cout = carry;
    end

endmodule

// File: logic/kogge_stone_adder.sv
`timescale 1ns/1ns

module kogge_stone_adder #(
    parameter int WIDTH = 14
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    localparam int LEVELS = $clog2(WIDTH);

    // level l holds group generate and propagate spanning 2**l bits.
    for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
        logic [WIDTH-1:0] g;
        logic [WIDTH-1:0] p;

        if (l == 0) begin : g_init
            assign g = x & y;
            assign p = x ^ y;
        end else begin : g_prefix
            localparam int SPAN = 1 << (l - 1);

            for (genvar i = 0; i < WIDTH; i++) begin : g_bit
                if (i < SPAN) begin : g_pass
                    assign g[i] = g_lvl[l-1].g[i];
                    assign p[i] = g_lvl[l-1].p[i];
                end else if (i < 2 * SPAN) begin : g_gray
                    // group reaches bit 0, only the carry is needed.
                    assign g[i] = g_lvl[l-1].g[i]
                                | (g_lvl[l-1].p[i] & g_lvl[l-1].g[i-SPAN]);
                    assign p[i] = g_lvl[l-1].p[i];
                end else begin : g_black
                    assign g[i] = g_lvl[l-1].g[i]
                                | (g_lvl[l-1].p[i] & g_lvl[l-1].g[i-SPAN]);
                    assign p[i] = g_lvl[l-1].p[i] & g_lvl[l-1].p[i-SPAN];
                end
            end
        end
    end

    // bit 0 has no incoming carry.
    assign sum[0] = g_lvl[0].p[0];

    for (genvar i = 1; i < WIDTH; i++) begin : g_sum
        assign sum[i] = g_lvl[0].p[i] ^ g_lvl[LEVELS].g[i-1];
    end

    assign cout = g_lvl[LEVELS].g[WIDTH-1];

endmodule

// File: logic/mac_datapath.sv
`timescale 1ns/1ns

module mac_datapath #(
    parameter int ACC_W = 24
) (
    input logic    clk,
    input logic    arst_n,
    mac_if.dp_mp   bus
);

    logic                              s1_valid;
    mul_pkg::mac_op_e                  s1_op;
    logic [mul_pkg::OPERAND_W-1:0]     s1_a;
    logic [mul_pkg::OPERAND_W-1:0]     s1_b;

    logic                              s2_valid;
    mul_pkg::mac_op_e                  s2_op;
    logic [mul_pkg::PRODUCT_W-1:0]     s2_product;

    logic [mul_pkg::PRODUCT_W-1:0]     product;
    logic [ACC_W-1:0]                  product_ext;
    logic [ACC_W-1:0]                  acc_q;
    logic                              retire_q;

    array_multiplier mult_i (
        .a(s1_a),
        .b(s1_b),
        .product(product)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= bus.launch;
            s2_valid <= s1_valid;
        end
    end

    // stage 1 operands, stage 2 product.
    always_ff @(posedge clk) begin
        if (bus.launch) begin
            s1_op <= bus.op;
            s1_a  <= bus.a;
            s1_b  <= bus.b;
        end
        if (s1_valid) begin
            s2_op      <= s1_op;
            s2_product <= product;
        end
    end

    assign product_ext = {{(ACC_W - mul_pkg::PRODUCT_W){1'b0}}, s2_product};

    // stage 3, sums wrap at ACC_W bits.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q    <= '0;
            retire_q <= 1'b0;
        end else begin
            retire_q <= s2_valid;
            if (s2_valid) begin
                case (s2_op)
                    mul_pkg::OP_MUL: acc_q <= product_ext;
                    mul_pkg::OP_MAC: acc_q <= acc_q + product_ext;
                    mul_pkg::OP_CLR: acc_q <= '0;
                    default:         acc_q <= acc_q;
                endcase
            end
        end
    end

    assign bus.acc    = acc_q;
    assign bus.retire = retire_q;
    // an op stays in flight until the retire cycle has passed.
    assign bus.busy   = s1_valid | s2_valid | retire_q;

endmodule

// File: logic/mac_if.sv
`timescale 1ns/1ns

interface mac_if #(
    parameter int ACC_W = 24
) ();

    // launched operation, valid for one cycle with launch.
    logic                              launch;
    mul_pkg::mac_op_e                  op;
    logic [mul_pkg::OPERAND_W-1:0]     a;
    logic [mul_pkg::OPERAND_W-1:0]     b;

    // datapath results and status.
    logic [ACC_W-1:0]                  acc;
    logic                              retire;
    logic                              busy;

    modport regs_mp (
        output launch, op, a, b,
        input  acc, retire, busy
    );

    modport dp_mp (
        input  launch, op, a, b,
        output acc, retire, busy
    );

endinterface

// File: logic/mac_regs.sv
`timescale 1ns/1ns

module mac_regs #(
    parameter int ACC_W = 24
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [mul_pkg::APB_AW-1:0]    paddr,
    input  logic [mul_pkg::APB_DW-1:0]    pwdata,
    output logic [mul_pkg::APB_DW-1:0]    prdata,
    output logic                          pslverr,
    mac_if.regs_mp                        bus
);

    logic                                  access;
    logic                                  err;
    logic                                  wr_ok;
    logic [1:0]                            ctrl_op;
    logic [2*mul_pkg::OPERAND_W-1:0]       operands_q;
    logic                                  launch_q;
    mul_pkg::mac_op_e                      op_q;
    logic [mul_pkg::COUNT_W-1:0]           count_q;

    assign access  = psel & penable;
    assign ctrl_op = pwdata[1:0];

    // slave error decode.
    always_comb begin
        case (paddr)
            mul_pkg::ADDR_OPERANDS: err = 1'b0;
            mul_pkg::ADDR_CTRL:     err = !pwrite || (ctrl_op == mul_pkg::OP_RSVD);
            mul_pkg::ADDR_RESULT,
            mul_pkg::ADDR_STATUS:   err = pwrite;
            default:                err = 1'b1;
        endcase
    end

    assign pslverr = access & err;
    assign wr_ok   = access & pwrite & ~err;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operands_q <= '0;
            launch_q   <= 1'b0;
            count_q    <= '0;
        end else begin
            if (wr_ok && paddr == mul_pkg::ADDR_OPERANDS) begin
                operands_q <= pwdata[2*mul_pkg::OPERAND_W-1:0];
            end
            launch_q <= wr_ok && (paddr == mul_pkg::ADDR_CTRL);
            // wraps at 256.
            if (bus.retire) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && paddr == mul_pkg::ADDR_CTRL) begin
            op_q <= mul_pkg::mac_op_e'(ctrl_op);
        end
    end

    assign bus.launch = launch_q;
    assign bus.op     = op_q;
    assign bus.a      = operands_q[mul_pkg::OPERAND_W-1:0];
    assign bus.b      = operands_q[2*mul_pkg::OPERAND_W-1:mul_pkg::OPERAND_W];

    // read data, zero outside a read access.
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                mul_pkg::ADDR_OPERANDS: prdata[2*mul_pkg::OPERAND_W-1:0] = operands_q;
                mul_pkg::ADDR_RESULT:   prdata[ACC_W-1:0] = bus.acc;
                mul_pkg::ADDR_STATUS:   prdata[mul_pkg::COUNT_W:0] = {bus.busy, count_q};
                default:                prdata = '0;
            endcase
        end
    end

endmodule

// File: logic/mac_top.sv
`timescale 1ns/1ns

module mac_top #(
    parameter int ACC_W = 24
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [mul_pkg::APB_AW-1:0]    paddr,
    input  logic [mul_pkg::APB_DW-1:0]    pwdata,
    output logic [mul_pkg::APB_DW-1:0]    prdata,
    output logic                          pready,
    output logic                          pslverr
);

    mac_if #(.ACC_W(ACC_W)) mac_bus ();

    mac_regs #(.ACC_W(ACC_W)) regs_i (
        .clk(clk),
        .arst_n(arst_n),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pslverr(pslverr),
        .bus(mac_bus.regs_mp)
    );

    mac_datapath #(.ACC_W(ACC_W)) dp_i (
        .clk(clk),
        .arst_n(arst_n),
        .bus(mac_bus.dp_mp)
    );

    // zero wait state slave.
    assign pready = 1'b1;

endmodule

// File: logic/mul_pkg.sv
package mul_pkg;

    // operand and product widths of the 8x8 multiplier.
    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 16;

    // apb address and data widths.
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // completion counter width in STATUS.
    localparam int COUNT_W = 8;

    // operation codes written to CTRL[1:0].
    typedef enum logic [1:0] {
        OP_MUL  = 2'd0,
        OP_MAC  = 2'd1,
        OP_CLR  = 2'd2,
        OP_RSVD = 2'd3
    } mac_op_e;

    // register byte addresses.
    localparam logic [APB_AW-1:0] ADDR_OPERANDS = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_CTRL     = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_RESULT   = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_STATUS   = 8'h0C;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; the result is taken from sim.log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mac_top \
    -f sources.f --Mdir obj_dir -o sim_tb_mac_top > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb_mac_top > sim.log 2>&1
grep -q '^STATUS: PASS$' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sources.f
logic/mul_pkg.sv
logic/mac_if.sv
logic/cla_block.sv
logic/kogge_stone_adder.sv
logic/array_multiplier.sv
logic/mac_datapath.sv
logic/mac_regs.sv
logic/mac_top.sv
testbench/tb_mac_top.sv

// File: testbench/tb_mac_top.sv
`timescale 1ns/1ns

module tb_mac_top;

    localparam int ACC_W = 24;
    // the tests take roughly 2800 cycles.
    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int               seed;
    int               errors = 0;
    int               timeouts = 0;
    int               cycle_count = 0;
    logic [ACC_W-1:0] model_acc;
    logic [7:0]       exp_count;

    mac_top #(.ACC_W(ACC_W)) dut_i (
        .clk(clk),
        .arst_n(arst_n),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        // sampled in the middle of the access phase.
        @(negedge clk);
        err = pslverr;
        check_value("pready", {31'd0, pready}, 32'd1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_value("pready", {31'd0, pready}, 32'd1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_value("pslverr", {31'd0, err}, 32'd0);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        check_value("pslverr", {31'd0, err}, 32'd0);
    endtask

    task automatic wait_count(input logic [7:0] target);
        logic [31:0] status;
        logic        err;
        apb_read(mul_pkg::ADDR_STATUS, status, err);
        while (status[7:0] != target) begin
            apb_read(mul_pkg::ADDR_STATUS, status, err);
        end
    endtask

    // writes CTRL and advances the reference accumulator.
    task automatic launch_op(input mul_pkg::mac_op_e op, input logic [7:0] a,
                             input logic [7:0] b);
        logic [15:0] prod;
        prod = {8'h00, a} * {8'h00, b};
        write_reg(mul_pkg::ADDR_CTRL, {30'd0, op});
        exp_count = exp_count + 8'd1;
        case (op)
            mul_pkg::OP_MUL: model_acc = {8'h00, prod};
            mul_pkg::OP_MAC: model_acc = model_acc + {8'h00, prod};
            default:         model_acc = '0;
        endcase
    endtask

    task automatic run_op(input mul_pkg::mac_op_e op, input logic [7:0] a,
                          input logic [7:0] b);
        logic [31:0] rdata;
        write_reg(mul_pkg::ADDR_OPERANDS, {16'd0, b, a});
        launch_op(op, a, b);
        wait_count(exp_count);
        read_reg(mul_pkg::ADDR_RESULT, rdata);
        check_value("RESULT", rdata, {8'h00, model_acc});
    endtask

    task automatic check_reset_state();
        logic [31:0] rdata;
        read_reg(mul_pkg::ADDR_RESULT, rdata);
        check_value("RESULT", rdata, 32'd0);
        read_reg(mul_pkg::ADDR_STATUS, rdata);
        check_value("STATUS", rdata, 32'd0);
        read_reg(mul_pkg::ADDR_OPERANDS, rdata);
        check_value("OPERANDS", rdata, 32'd0);
    endtask

    task automatic run_mul_cases();
        logic [7:0] a;
        logic [7:0] b;
        run_op(mul_pkg::OP_MUL, 8'd0, 8'd0);
        run_op(mul_pkg::OP_MUL, 8'd1, 8'd255);
        run_op(mul_pkg::OP_MUL, 8'd255, 8'd255);
        run_op(mul_pkg::OP_MUL, 8'd128, 8'd2);
        // walking ones on each operand against all ones.
        for (int i = 0; i < 8; i++) begin
            run_op(mul_pkg::OP_MUL, 8'(1 << i), 8'hff);
            run_op(mul_pkg::OP_MUL, 8'hff, 8'(1 << i));
        end
        for (int i = 0; i < 60; i++) begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            run_op(mul_pkg::OP_MUL, a, b);
        end
    endtask

    task automatic run_mac_sequence();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [31:0] rdata;
        run_op(mul_pkg::OP_MUL, 8'd3, 8'd7);
        for (int i = 0; i < 40; i++) begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            run_op(mul_pkg::OP_MAC, a, b);
        end
        // 260 products of 65025 exceed 2**24 from any start value.
        write_reg(mul_pkg::ADDR_OPERANDS, {16'd0, 8'hff, 8'hff});
        for (int i = 0; i < 260; i++) begin
            launch_op(mul_pkg::OP_MAC, 8'hff, 8'hff);
        end
        wait_count(exp_count);
        read_reg(mul_pkg::ADDR_RESULT, rdata);
        check_value("RESULT", rdata, {8'h00, model_acc});
    endtask

    task automatic clear_and_restart();
        run_op(mul_pkg::OP_MAC, 8'd200, 8'd100);
        run_op(mul_pkg::OP_CLR, 8'd0, 8'd0);
        run_op(mul_pkg::OP_MAC, 8'd17, 8'd9);
    endtask

    task automatic probe_error_responses();
        logic [31:0] rdata;
        logic        err;
        apb_read(mul_pkg::ADDR_CTRL, rdata, err);
        check_value("pslverr on CTRL read", {31'd0, err}, 32'd1);
        apb_write(mul_pkg::ADDR_RESULT, 32'h1234, err);
        check_value("pslverr on RESULT write", {31'd0, err}, 32'd1);
        apb_write(mul_pkg::ADDR_STATUS, 32'h5678, err);
        check_value("pslverr on STATUS write", {31'd0, err}, 32'd1);
        apb_read(8'h10, rdata, err);
        check_value("pslverr on 0x10 read", {31'd0, err}, 32'd1);
        apb_write(8'h10, 32'h9abc, err);
        check_value("pslverr on 0x10 write", {31'd0, err}, 32'd1);
        apb_write(mul_pkg::ADDR_CTRL, 32'd3, err);
        check_value("pslverr on opcode 3", {31'd0, err}, 32'd1);
        // long enough for a stray launch to retire.
        repeat (6) @(posedge clk);
        read_reg(mul_pkg::ADDR_STATUS, rdata);
        check_value("STATUS", rdata, {24'd0, exp_count});
        read_reg(mul_pkg::ADDR_RESULT, rdata);
        check_value("RESULT", rdata, {8'h00, model_acc});
    endtask

    task automatic issue_back_to_back();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [31:0] rdata;
        for (int k = 0; k < 5; k++) begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            write_reg(mul_pkg::ADDR_OPERANDS, {16'd0, b, a});
            launch_op(mul_pkg::OP_MAC, a, b);
        end
        // the last MAC is still in the pipeline.
        read_reg(mul_pkg::ADDR_STATUS, rdata);
        check_value("STATUS busy", {31'd0, rdata[8]}, 32'd1);
        wait_count(exp_count);
        read_reg(mul_pkg::ADDR_RESULT, rdata);
        check_value("RESULT", rdata, {8'h00, model_acc});
        read_reg(mul_pkg::ADDR_STATUS, rdata);
        check_value("STATUS", rdata, {24'd0, exp_count});
    endtask

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        timeouts++;
        $display("the run timed out after %0d cycles before the tests finished", cycle_count);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed      = 32'ha9c9bece;
        model_acc = '0;
        exp_count = '0;
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        check_reset_state();
        run_mul_cases();
        run_mac_sequence();
        clear_and_restart();
        probe_error_responses();
        issue_back_to_back();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
